// ==== files.f ====
+incdir+include
rtl/blk_pkg.sv
rtl/axil_ram.sv
rtl/axil_rd_master.sv
rtl/axil_wr_master.sv
rtl/copy_ctrl.sv
rtl/blk_copy_top.sv
verif/tb_clk_gen.sv
verif/tb_blk_copy.sv

// ==== include/blk_config.svh ====
`ifndef BLK_CONFIG_SVH
`define BLK_CONFIG_SVH

// data bus width in bits
`define BLK_DATA_W 32
// byte address width, 4 KiB of RAM
`define BLK_ADDR_W 12
// bytes per data word
`define BLK_STRB_W (`BLK_DATA_W / 8)
// word index width, byte address minus the two byte-lane bits
`define BLK_WIDX_W (`BLK_ADDR_W - 2)
// command word count width
`define BLK_LEN_W 10
// value every RAM word holds before any write
`define BLK_RAM_FILL 32'h0000_0014

`endif

// ==== rtl/axil_ram.sv ====
`timescale 1ns/1ps
`include "blk_config.svh"

module axil_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  blk_pkg::axil_aw_t      aw,
    output logic                   awready,
    input  blk_pkg::axil_w_t       w,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    input  blk_pkg::axil_ar_t      ar,
    output logic                   arready,
    output blk_pkg::axil_r_t       r,
    input  logic                   rready,
    input  blk_pkg::dbg_wr_t       dbg_wr,
    input  logic [`BLK_WIDX_W-1:0] dbg_rd_addr,
    output logic [`BLK_DATA_W-1:0] dbg_rd_data
);

    localparam int WORDS = 1 << `BLK_WIDX_W;

    logic [`BLK_DATA_W-1:0] mem [WORDS];

    logic                   awready_q;
    logic                   wready_q;
    logic                   bvalid_q;
    logic                   arready_q;
    logic                   rvalid_q;
    logic [`BLK_DATA_W-1:0] rdata_q;

    logic                   awready_d;
    logic                   wready_d;
    logic                   bvalid_d;
    logic                   arready_d;
    logic                   rvalid_d;
    logic                   mem_wr_en;
    logic                   mem_rd_en;

    logic [`BLK_WIDX_W-1:0] aw_idx;
    logic [`BLK_WIDX_W-1:0] ar_idx;

    // byte lane bits dropped
    assign aw_idx = aw.addr[`BLK_ADDR_W-1 -: `BLK_WIDX_W];
    assign ar_idx = ar.addr[`BLK_ADDR_W-1 -: `BLK_WIDX_W];

    assign awready = awready_q;
    assign wready  = wready_q;
    assign bvalid  = bvalid_q;
    assign arready = arready_q;
    assign r       = '{data: rdata_q, valid: rvalid_q};

    // debug read, combinational
    assign dbg_rd_data = mem[dbg_rd_addr];

    // known contents at power up
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = `BLK_RAM_FILL;
        end
    end

    // write side: accept aw and w together, one word at a time
    always_comb begin
        mem_wr_en = 1'b0;
        awready_d = 1'b0;
        wready_d  = 1'b0;
        // b holds until taken
        bvalid_d  = bvalid_q && !bready;
        if (aw.valid && w.valid && (!bvalid_q || bready) &&
            !awready_q && !wready_q) begin
            awready_d = 1'b1;
            wready_d  = 1'b1;
            bvalid_d  = 1'b1;
            mem_wr_en = 1'b1;
        end
    end

    // read side: arready for one cycle, rvalid the cycle after the ar handshake
    always_comb begin
        mem_rd_en = 1'b0;
        arready_d = 1'b0;
        rvalid_d  = rvalid_q && !rready;
        if (ar.valid && arready_q) begin
            rvalid_d  = 1'b1;
            mem_rd_en = 1'b1;
        end else if (ar.valid && (!rvalid_q || rready) && !arready_q) begin
            arready_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            awready_q <= awready_d;
            wready_q  <= wready_d;
            bvalid_q  <= bvalid_d;
            arready_q <= arready_d;
            rvalid_q  <= rvalid_d;
        end
    end

    // storage and read data register
    always @(posedge clk) begin
        for (int b = 0; b < `BLK_STRB_W; b++) begin
            if (mem_wr_en && w.strb[b]) begin
                mem[aw_idx][8*b +: 8] <= w.data[8*b +: 8];
            end
        end
        // debug write last, only used while engine idle
        if (dbg_wr.en) begin
            mem[dbg_wr.addr] <= dbg_wr.data;
        end
        if (mem_rd_en) begin
            rdata_q <= mem[ar_idx];
        end
    end

endmodule

// ==== rtl/axil_rd_master.sv ====
`timescale 1ns/1ps
`include "blk_config.svh"

module axil_rd_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_start,
    input  logic [`BLK_ADDR_W-1:0] rd_addr,
    output logic                   rd_done,
    output logic [`BLK_DATA_W-1:0] rd_data,
    output blk_pkg::axil_ar_t      ar,
    input  logic                   arready,
    input  blk_pkg::axil_r_t       r,
    output logic                   rready
);

    logic                   arvalid_q;
    logic                   r_pend_q;
    logic                   done_q;
    logic [`BLK_ADDR_W-1:0] addr_q;
    logic [`BLK_DATA_W-1:0] data_q;
    logic                   r_fire;

    // never back-pressure r
    assign rready = 1'b1;
    assign r_fire = r_pend_q && r.valid && rready;

    assign ar      = '{addr: addr_q, valid: arvalid_q};
    assign rd_done = done_q;
    assign rd_data = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid_q <= 1'b0;
            r_pend_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            // done one cycle after r handshake
            done_q <= r_fire;
            if (rd_start) begin
                arvalid_q <= 1'b1;
                r_pend_q  <= 1'b1;
            end else begin
                // ar drops on its handshake
                if (arvalid_q && arready) begin
                    arvalid_q <= 1'b0;
                end
                if (r_fire) begin
                    r_pend_q <= 1'b0;
                end
            end
        end
    end

    // address and captured word
    always_ff @(posedge clk) begin
        if (rd_start) begin
            addr_q <= rd_addr;
        end
        if (r_fire) begin
            data_q <= r.data;
        end
    end

endmodule

// ==== rtl/axil_wr_master.sv ====
`timescale 1ns/1ps
`include "blk_config.svh"

module axil_wr_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_start,
    input  logic [`BLK_ADDR_W-1:0] wr_addr,
    input  logic [`BLK_DATA_W-1:0] wr_data,
    input  logic [`BLK_STRB_W-1:0] wr_strb,
    output logic                   wr_done,
    output blk_pkg::axil_aw_t      aw,
    input  logic                   awready,
    output blk_pkg::axil_w_t       w,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);

    logic                   awvalid_q;
    logic                   wvalid_q;
    logic                   b_pend_q;
    logic                   done_q;
    logic [`BLK_ADDR_W-1:0] addr_q;
    logic [`BLK_DATA_W-1:0] data_q;
    logic [`BLK_STRB_W-1:0] strb_q;
    logic                   b_fire;

    // always accept the response
    assign bready = 1'b1;
    assign b_fire = b_pend_q && bvalid && bready;

    assign aw      = '{addr: addr_q, valid: awvalid_q};
    assign w       = '{data: data_q, strb: strb_q, valid: wvalid_q};
    assign wr_done = done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            b_pend_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            // pulse the cycle after b handshake
            done_q <= b_fire;
            if (wr_start) begin
                awvalid_q <= 1'b1;
                wvalid_q  <= 1'b1;
                b_pend_q  <= 1'b1;
            end else begin
                // each valid drops on its own handshake
                if (awvalid_q && awready) begin
                    awvalid_q <= 1'b0;
                end
                if (wvalid_q && wready) begin
                    wvalid_q <= 1'b0;
                end
                if (b_fire) begin
                    b_pend_q <= 1'b0;
                end
            end
        end
    end

    // payload held until both handshakes
    always_ff @(posedge clk) begin
        if (wr_start) begin
            addr_q <= wr_addr;
            data_q <= wr_data;
            strb_q <= wr_strb;
        end
    end

endmodule

// ==== rtl/blk_copy_top.sv ====
`timescale 1ns/1ps
`include "blk_config.svh"

module blk_copy_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_req,
    input  blk_pkg::blk_cmd_t      cmd,
    output logic                   cmd_ack,
    input  blk_pkg::dbg_wr_t       dbg_wr,
    input  logic [`BLK_WIDX_W-1:0] dbg_rd_addr,
    output logic [`BLK_DATA_W-1:0] dbg_rd_data
);

    // controller to masters
    logic                   rd_start;
    logic [`BLK_ADDR_W-1:0] rd_addr;
    logic                   rd_done;
    logic [`BLK_DATA_W-1:0] rd_data;
    logic                   wr_start;
    logic [`BLK_ADDR_W-1:0] wr_addr;
    logic [`BLK_DATA_W-1:0] wr_data;
    logic [`BLK_STRB_W-1:0] wr_strb;
    logic                   wr_done;

    // axi-lite link
    blk_pkg::axil_aw_t      aw;
    logic                   awready;
    blk_pkg::axil_w_t       w;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    blk_pkg::axil_ar_t      ar;
    logic                   arready;
    blk_pkg::axil_r_t       r;
    logic                   rready;

    copy_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd      (cmd),
        .cmd_ack  (cmd_ack),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .wr_done  (wr_done)
    );

    axil_rd_master u_rd (
        .clk      (clk),
        .rst      (rst),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .ar       (ar),
        .arready  (arready),
        .r        (r),
        .rready   (rready)
    );

    axil_wr_master u_wr (
        .clk      (clk),
        .rst      (rst),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .wr_done  (wr_done),
        .aw       (aw),
        .awready  (awready),
        .w        (w),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

    axil_ram u_ram (
        .clk         (clk),
        .rst         (rst),
        .aw          (aw),
        .awready     (awready),
        .w           (w),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready),
        .dbg_wr      (dbg_wr),
        .dbg_rd_addr (dbg_rd_addr),
        .dbg_rd_data (dbg_rd_data)
    );

endmodule

// ==== rtl/blk_pkg.sv ====
`include "blk_config.svh"

package blk_pkg;

    // command opcode
    typedef enum logic {
        OP_COPY = 1'b0,
        OP_FILL = 1'b1
    } blk_op_e;

    // one argument word, read per op
    typedef union packed {
        // copy source byte address, low BLK_ADDR_W bits used
        logic [`BLK_DATA_W-1:0] src_addr;
        // fill word
        logic [`BLK_DATA_W-1:0] pattern;
    } blk_arg_u;

    // host command, len of zero is legal
    typedef struct packed {
        blk_op_e                op;
        blk_arg_u               arg;
        logic [`BLK_ADDR_W-1:0] dst_addr;
        logic [`BLK_LEN_W-1:0]  len;
        logic [`BLK_STRB_W-1:0] strb;
    } blk_cmd_t;

    // axi-lite write address
    typedef struct packed {
        logic [`BLK_ADDR_W-1:0] addr;
        logic                   valid;
    } axil_aw_t;

    // axi-lite write data
    typedef struct packed {
        logic [`BLK_DATA_W-1:0] data;
        logic [`BLK_STRB_W-1:0] strb;
        logic                   valid;
    } axil_w_t;

    // axi-lite read address
    typedef struct packed {
        logic [`BLK_ADDR_W-1:0] addr;
        logic                   valid;
    } axil_ar_t;

    // axi-lite read data, response is always okay
    typedef struct packed {
        logic [`BLK_DATA_W-1:0] data;
        logic                   valid;
    } axil_r_t;

    // debug write port, word addressed
    typedef struct packed {
        logic [`BLK_WIDX_W-1:0] addr;
        logic [`BLK_DATA_W-1:0] data;
        logic                   en;
    } dbg_wr_t;

endpackage

// ==== rtl/copy_ctrl.sv ====
`timescale 1ns/1ps
`include "blk_config.svh"

module copy_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_req,
    input  blk_pkg::blk_cmd_t      cmd,
    output logic                   cmd_ack,
    output logic                   rd_start,
    output logic [`BLK_ADDR_W-1:0] rd_addr,
    input  logic                   rd_done,
    input  logic [`BLK_DATA_W-1:0] rd_data,
    output logic                   wr_start,
    output logic [`BLK_ADDR_W-1:0] wr_addr,
    output logic [`BLK_DATA_W-1:0] wr_data,
    output logic [`BLK_STRB_W-1:0] wr_strb,
    input  logic                   wr_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_NEXT,
        S_RD,
        S_WR,
        S_ACK
    } state_e;

    // one word in bytes
    localparam logic [`BLK_ADDR_W-1:0] STEP = `BLK_STRB_W;

    state_e                 state_q;
    logic                   cmd_ack_q;
    logic                   rd_start_q;
    logic                   wr_start_q;

    blk_pkg::blk_op_e       op_q;
    blk_pkg::blk_arg_u      arg_q;
    logic [`BLK_STRB_W-1:0] strb_q;
    logic [`BLK_ADDR_W-1:0] src_q;
    logic [`BLK_ADDR_W-1:0] dst_q;
    logic [`BLK_LEN_W-1:0]  remain_q;
    logic [`BLK_DATA_W-1:0] wr_data_q;

    assign cmd_ack  = cmd_ack_q;
    assign rd_start = rd_start_q;
    assign rd_addr  = src_q;
    assign wr_start = wr_start_q;
    assign wr_addr  = dst_q;
    assign wr_data  = wr_data_q;
    assign wr_strb  = strb_q;

    // sequencing fsm
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= S_IDLE;
            cmd_ack_q  <= 1'b0;
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
        end else begin
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (cmd_req) begin
                        state_q <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    // out of words, ack two cycles after sampling when len is zero
                    if (remain_q == '0) begin
                        cmd_ack_q <= 1'b1;
                        state_q   <= S_ACK;
                    end else if (op_q == blk_pkg::OP_COPY) begin
                        rd_start_q <= 1'b1;
                        state_q    <= S_RD;
                    end else begin
                        wr_start_q <= 1'b1;
                        state_q    <= S_WR;
                    end
                end
                S_RD: begin
                    // read word in hand, write it out
                    if (rd_done) begin
                        wr_start_q <= 1'b1;
                        state_q    <= S_WR;
                    end
                end
                S_WR: begin
                    if (wr_done) begin
                        state_q <= S_NEXT;
                    end
                end
                S_ACK: begin
                    // hold ack until host drops req
                    if (!cmd_req) begin
                        cmd_ack_q <= 1'b0;
                        state_q   <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // command latch, counters and write word
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cmd_req) begin
            op_q     <= cmd.op;
            arg_q    <= cmd.arg;
            strb_q   <= cmd.strb;
            src_q    <= cmd.arg.src_addr[`BLK_ADDR_W-1:0];
            dst_q    <= cmd.dst_addr;
            remain_q <= cmd.len;
        end
        // fill takes the pattern view of the argument
        if (state_q == S_NEXT && remain_q != '0 && op_q == blk_pkg::OP_FILL) begin
            wr_data_q <= arg_q.pattern;
        end
        if (state_q == S_RD && rd_done) begin
            wr_data_q <= rd_data;
        end
        // step both pointers once the word is written
        if (state_q == S_WR && wr_done) begin
            remain_q <= remain_q - 1'b1;
            src_q    <= src_q + STEP;
            dst_q    <= dst_q + STEP;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the block copy testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_blk_copy -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// ==== verif/tb_blk_copy.sv ====
`timescale 1ns/1ps
`include "blk_config.svh"

module tb_blk_copy;

    localparam int WORDS       = 1 << `BLK_WIDX_W;
    localparam int PRELOAD     = 64;
    localparam int NUM_STEPS   = 8;
    localparam int RST_TIMEOUT = 20;
    localparam int ACK_TIMEOUT = 2000;

    // one table row: command plus expected ack latency, 0 when not fixed
    typedef struct packed {
        blk_pkg::blk_cmd_t cmd;
        logic [3:0]        ack_lat;
    } step_t;

    logic                   clk;
    logic                   rst;
    logic                   cmd_req;
    blk_pkg::blk_cmd_t      cmd;
    logic                   cmd_ack;
    blk_pkg::dbg_wr_t       dbg_wr;
    logic [`BLK_WIDX_W-1:0] dbg_rd_addr;
    logic [`BLK_DATA_W-1:0] dbg_rd_data;

    logic [`BLK_DATA_W-1:0] model [WORDS];
    step_t                  steps [NUM_STEPS];
    int                     errors;
    int                     checks;
    bit                     timed_out;

    tb_clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    blk_copy_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_ack     (cmd_ack),
        .dbg_wr      (dbg_wr),
        .dbg_rd_addr (dbg_rd_addr),
        .dbg_rd_data (dbg_rd_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // arg is read as src_addr for copy, pattern for fill
    function automatic step_t make_step(input blk_pkg::blk_op_e op, input logic [31:0] arg,
                                        input logic [`BLK_ADDR_W-1:0] dst,
                                        input logic [`BLK_LEN_W-1:0] len,
                                        input logic [`BLK_STRB_W-1:0] strb,
                                        input logic [3:0] ack_lat);
        step_t s;
        s.cmd.op       = op;
        s.cmd.arg      = arg;
        s.cmd.dst_addr = dst;
        s.cmd.len      = len;
        s.cmd.strb     = strb;
        s.ack_lat      = ack_lat;
        return s;
    endfunction

    // byte lanes with strb set take the new byte
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < `BLK_STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    // reference rule, one word at a time in ascending order
    task automatic apply_model(input blk_pkg::blk_cmd_t c);
        logic [`BLK_WIDX_W-1:0] src_idx;
        logic [`BLK_WIDX_W-1:0] dst_idx;
        logic [`BLK_DATA_W-1:0] word;
        src_idx = c.arg.src_addr[`BLK_ADDR_W-1:2];
        dst_idx = c.dst_addr[`BLK_ADDR_W-1:2];
        for (int i = 0; i < int'(c.len); i++) begin
            if (c.op == blk_pkg::OP_COPY) begin
                word = model[src_idx];
            end else begin
                word = c.arg.pattern;
            end
            model[dst_idx] = merge_bytes(model[dst_idx], word, c.strb);
            src_idx = src_idx + 1'b1;
            dst_idx = dst_idx + 1'b1;
        end
    endtask

    // address set on the falling edge, data taken at the next rising edge
    task automatic read_word(input logic [`BLK_WIDX_W-1:0] idx, output logic [31:0] data);
        @(negedge clk);
        dbg_rd_addr = idx;
        @(posedge clk);
        data = dbg_rd_data;
    endtask

    task automatic check_word(input logic [`BLK_WIDX_W-1:0] idx);
        logic [31:0] got;
        read_word(idx, got);
        check_value($sformatf("dbg_rd_data[%0d]", idx), got, model[idx]);
    endtask

    // destination range plus one word past each end
    task automatic check_window(input blk_pkg::blk_cmd_t c);
        int base;
        base = int'(c.dst_addr[`BLK_ADDR_W-1:2]);
        for (int i = -1; i <= int'(c.len); i++) begin
            check_word(`BLK_WIDX_W'(base + i));
        end
    endtask

    task automatic preload_memory();
        logic [31:0] val;
        for (int i = 0; i < PRELOAD; i++) begin
            val = $urandom();
            @(negedge clk);
            dbg_wr   = '{addr: `BLK_WIDX_W'(i), data: val, en: 1'b1};
            model[i] = val;
        end
        @(negedge clk);
        dbg_wr = '0;
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
    endtask

    // full four-phase exchange for one table row
    task automatic run_command(input int k);
        int cycles;
        // ack must be low before a new request
        check_value("cmd_ack", 32'(cmd_ack), 32'h0);
        @(negedge clk);
        cmd     = steps[k].cmd;
        cmd_req = 1'b1;
        cycles  = 0;
        while (cmd_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cmd_ack !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            cmd_req   = 1'b0;
            $display("timeout: cmd_ack never rose for command %0d", k);
        end else begin
            if (steps[k].ack_lat != 4'd0) begin
                check_value("cmd_ack latency", 32'(cycles), 32'(steps[k].ack_lat));
            end
            // ack has to hold while the request is still up
            @(negedge clk);
            check_value("cmd_ack", 32'(cmd_ack), 32'h1);
            // release the request, ack has to follow it down
            cmd_req = 1'b0;
            cycles  = 0;
            while (cmd_ack !== 1'b0 && cycles < ACK_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (cmd_ack !== 1'b0) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: cmd_ack stayed high after command %0d", k);
            end else begin
                apply_model(steps[k].cmd);
                check_window(steps[k].cmd);
            end
        end
    endtask

    initial begin
        cmd_req     = 1'b0;
        cmd         = '0;
        dbg_wr      = '0;
        dbg_rd_addr = '0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        void'($urandom(32'hbf0c_5b89));
        for (int i = 0; i < WORDS; i++) begin
            model[i] = `BLK_RAM_FILL;
        end

        // full strobe copy and fill
        steps[0] = make_step(blk_pkg::OP_COPY, 32'h0000_0000, 12'h200, 10'd8, 4'hf, 4'd0);
        steps[1] = make_step(blk_pkg::OP_FILL, 32'ha5c3_1e70, 12'h300, 10'd5, 4'hf, 4'd0);
        // partial strobes over preloaded words
        steps[2] = make_step(blk_pkg::OP_COPY, 32'h0000_0028, 12'h0a0, 10'd6, 4'h5, 4'd0);
        steps[3] = make_step(blk_pkg::OP_FILL, 32'hdead_beef, 12'h0c8, 10'd4, 4'ha, 4'd0);
        // zero length, ack two cycles after the sample
        steps[4] = make_step(blk_pkg::OP_COPY, 32'h0000_0010, 12'h4b0, 10'd0, 4'hf, 4'd2);
        steps[5] = make_step(blk_pkg::OP_FILL, 32'h1111_2222, 12'h050, 10'd0, 4'hf, 4'd2);
        // near the top of memory, low lanes only
        steps[6] = make_step(blk_pkg::OP_FILL, 32'h0bad_cafe, 12'hfa0, 10'd3, 4'h3, 4'd0);
        // copy out of an earlier fill
        steps[7] = make_step(blk_pkg::OP_COPY, 32'h0000_0300, 12'h640, 10'd5, 4'hf, 4'd0);

        wait_reset();
        if (!timed_out) begin
            check_value("cmd_ack", 32'(cmd_ack), 32'h0);
            preload_memory();
        end
        for (int k = 0; k < NUM_STEPS; k++) begin
            if (timed_out) begin
                break;
            end
            run_command(k);
        end
        // untouched words must still hold the fill value
        if (!timed_out) begin
            for (int i = 0; i < WORDS; i++) begin
                check_word(`BLK_WIDX_W'(i));
            end
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over two rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
